// File: rtl/spi_defs.svh
`ifndef SPI_DEFS_SVH
`define SPI_DEFS_SVH

// ****************************************
// Widths
// ****************************************
`define SPI_CMD_W        12
`define SPI_DATA_W       8
`define SPI_ADDR_W       3
`define SPI_AXI_AW       4
`define SPI_AXI_DW       32
`define SPI_DIV_W        8

// ****************************************
// Register map and reset values
// ****************************************
`define SPI_REG_CTRL     4'h0
`define SPI_REG_CMD      4'h4
`define SPI_REG_STATUS   4'h8
`define SPI_REG_RXDATA   4'hC

`define SPI_CLK_DIV_RST  8'd4   // Half-period in clk cycles.
`define SPI_TURN_GAP_RST 8'd16  // Chip select high time between read phases.

`endif

// File: rtl/spi_pkg.sv
`default_nettype none

`include "spi_defs.svh"

package spi_pkg;

  typedef logic [`SPI_DATA_W-1:0] spi_byte_t;
  typedef logic [`SPI_ADDR_W-1:0] spi_addr_t;
  typedef logic [`SPI_DIV_W-1:0]  spi_div_t;
  typedef logic [`SPI_AXI_AW-1:0] axi_addr_t;
  typedef logic [`SPI_AXI_DW-1:0] axi_data_t;

  // Serial command word, sent most significant bit first.
  typedef struct packed {
    logic      write;
    spi_addr_t addr;
    spi_byte_t data;
  } spi_cmd_t;

  // Field order matches the CTRL register layout.
  typedef struct packed {
    spi_div_t turn_gap;
    spi_div_t clk_div;
  } spi_cfg_t;

  typedef enum logic [2:0] {
    idle,
    cmd_shift,
    turn_gap,
    rd_shift,
    done
  } spi_state_t;

endpackage

`default_nettype wire

// File: rtl/spi_axil_regs.sv
`default_nettype none

`include "spi_defs.svh"

module spi_axil_regs
  import spi_pkg::*;
(
  input  wire            clk,
  input  wire            rst_n,
  input  wire axi_addr_t awaddr,
  input  wire            awvalid,
  output logic           awready,
  input  wire axi_data_t wdata,
  input  wire            wvalid,
  output logic           wready,
  output logic [1:0]     bresp,
  output logic           bvalid,
  input  wire            bready,
  input  wire axi_addr_t araddr,
  input  wire            arvalid,
  output logic           arready,
  output axi_data_t      rdata,
  output logic [1:0]     rresp,
  output logic           rvalid,
  input  wire            rready,
  output spi_cmd_t       cmd,
  output logic           cmd_valid,
  output spi_cfg_t       cfg,
  input  wire            cmd_ready,
  input  wire            rd_valid,
  input  wire spi_byte_t rd_data
);

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  spi_cfg_t   ctrl_q;
  logic       busy;
  logic       rx_valid;
  spi_byte_t  rx_data_q;
  logic       wr_en;
  logic       rd_en;
  logic       cmd_wr;
  logic       rx_rd;
  logic [1:0] wr_resp;
  logic [1:0] rd_resp;
  axi_data_t  rd_word;

  assign wr_en  = awvalid && awready && wvalid && wready;
  assign rd_en  = arvalid && arready;
  assign cmd_wr = wr_en && (awaddr == `SPI_REG_CMD) && !busy; // Refused while busy.
  assign rx_rd  = rd_en && (araddr == `SPI_REG_RXDATA);
  assign cfg    = ctrl_q;

  // ****************************************
  // Write channel
  // ****************************************
  always_comb
  begin
    case (awaddr)
      `SPI_REG_CTRL, `SPI_REG_STATUS, `SPI_REG_RXDATA:
        wr_resp = resp_okay;
      `SPI_REG_CMD:
        wr_resp = busy ? resp_slverr : resp_okay;
      default:
        wr_resp = resp_slverr;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      bresp   <= resp_okay;
    end
    else
    begin
      awready <= awvalid && wvalid && !awready && !bvalid; // Single-cycle ready pulse.
      wready  <= awvalid && wvalid && !awready && !bvalid;
      if (wr_en)
      begin
        bvalid <= 1'b1;
        bresp  <= wr_resp;
      end
      else if (bready)
        bvalid <= 1'b0;
    end
  end

  // ****************************************
  // Registers and engine handshake
  // ****************************************
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ctrl_q    <= '{turn_gap: `SPI_TURN_GAP_RST, clk_div: `SPI_CLK_DIV_RST};
      cmd_valid <= 1'b0;
      busy      <= 1'b0;
      rx_valid  <= 1'b0;
      rx_data_q <= '0;
    end
    else
    begin
      if (wr_en && (awaddr == `SPI_REG_CTRL))
        ctrl_q <= spi_cfg_t'(wdata[$bits(spi_cfg_t)-1:0]);

      if (cmd_wr)
        cmd_valid <= 1'b1;
      else if (cmd_valid && cmd_ready)
        cmd_valid <= 1'b0;

      // The engine leaves idle right after the transfer, so ready high again means finished.
      if (cmd_wr)
        busy <= 1'b1;
      else if (busy && !cmd_valid && cmd_ready)
        busy <= 1'b0;

      if (rd_valid)
      begin
        rx_valid  <= 1'b1;
        rx_data_q <= rd_data;
      end
      else if (rx_rd)
        rx_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_wr)
      cmd <= spi_cmd_t'(wdata[`SPI_CMD_W-1:0]);
  end

  // ****************************************
  // Read channel
  // ****************************************
  always_comb
  begin
    rd_word = '0;
    rd_resp = resp_okay;
    case (araddr)
      `SPI_REG_CTRL:
        rd_word = axi_data_t'(ctrl_q);
      `SPI_REG_CMD:
        rd_word = '0;                      // CMD is write-only.
      `SPI_REG_STATUS:
        rd_word = axi_data_t'({rx_valid, busy});
      `SPI_REG_RXDATA:
        rd_word = axi_data_t'(rx_data_q);
      default:
        rd_resp = resp_slverr;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
      rresp   <= resp_okay;
    end
    else
    begin
      arready <= arvalid && !arready && !rvalid;
      if (rd_en)
      begin
        rvalid <= 1'b1;
        rresp  <= rd_resp;
      end
      else if (rready)
        rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rd_en)
      rdata <= rd_word;
  end

endmodule

`default_nettype wire

// File: rtl/spi_cmd_engine.sv
`default_nettype none

`include "spi_defs.svh"

module spi_cmd_engine
  import spi_pkg::*;
(
  input  wire           clk,
  input  wire           rst_n,
  input  wire spi_cmd_t cmd,
  input  wire           cmd_valid,
  output logic          cmd_ready,
  input  wire spi_cfg_t cfg,
  output logic          rd_valid,
  output spi_byte_t     rd_data,
  output logic          sclk,
  output logic          cs_n,
  output logic          mosi,
  input  wire           miso
);

  localparam int bit_cnt_w = $clog2(`SPI_CMD_W + 1);

  localparam logic [bit_cnt_w-1:0] wr_bits      = bit_cnt_w'(`SPI_CMD_W);
  localparam logic [bit_cnt_w-1:0] rd_hdr_bits  = bit_cnt_w'(`SPI_ADDR_W + 1);
  localparam logic [bit_cnt_w-1:0] rd_data_bits = bit_cnt_w'(`SPI_DATA_W);

  spi_state_t            state;
  spi_div_t              div_q;
  spi_div_t              gap_q;
  logic                  is_wr;
  spi_div_t              half_cnt;
  logic [bit_cnt_w-1:0]  bit_cnt;
  logic [bit_cnt_w-1:0]  n_bits;
  logic [`SPI_CMD_W-1:0] shift_q;
  logic                  shifting;
  logic                  half_done;
  logic                  in_bits;
  logic                  sclk_rise;
  logic                  sclk_fall;

  // ****************************************
  // Frame decode
  // ****************************************
  always_comb
  begin
    if (state == rd_shift)
      n_bits = rd_data_bits;
    else if (is_wr)
      n_bits = wr_bits;
    else
      n_bits = rd_hdr_bits;                // Write flag and address only.
  end

  assign shifting  = (state == cmd_shift) || (state == rd_shift);
  assign half_done = (half_cnt == div_q - 1'b1);
  assign in_bits   = (bit_cnt != n_bits);  // Low once the tail before cs_n rise starts.
  assign sclk_rise = shifting && in_bits && half_done && !sclk;
  assign sclk_fall = shifting && in_bits && half_done && sclk;

  assign cmd_ready = (state == idle);
  assign rd_valid  = (state == done) && !is_wr;
  assign rd_data   = shift_q[`SPI_DATA_W-1:0];
  assign mosi      = (state == cmd_shift) && in_bits && shift_q[`SPI_CMD_W-1];

  // ****************************************
  // Control FSM
  // ****************************************
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= idle;
      cs_n     <= 1'b1;
      sclk     <= 1'b0;
      half_cnt <= '0;
      bit_cnt  <= '0;
      is_wr    <= 1'b0;
      div_q    <= spi_div_t'(1);
      gap_q    <= spi_div_t'(1);
    end
    else
    begin
      case (state)
        idle:
        begin
          if (cmd_valid)
          begin
            state    <= cmd_shift;
            cs_n     <= 1'b0;
            half_cnt <= '0;
            bit_cnt  <= '0;
            is_wr    <= cmd.write;
            div_q    <= (cfg.clk_div == '0) ? spi_div_t'(1) : cfg.clk_div;
            gap_q    <= (cfg.turn_gap == '0) ? spi_div_t'(1) : cfg.turn_gap;
          end
        end

        cmd_shift, rd_shift:
        begin
          if (!half_done)
            half_cnt <= half_cnt + 1'b1;
          else
          begin
            half_cnt <= '0;
            if (in_bits)
            begin
              sclk <= ~sclk;
              if (sclk)
                bit_cnt <= bit_cnt + 1'b1; // A bit ends on its falling edge.
            end
            else
            begin
              cs_n <= 1'b1;
              if ((state == cmd_shift) && !is_wr)
                state <= turn_gap;
              else
                state <= done;
            end
          end
        end

        turn_gap:
        begin
          if (half_cnt == gap_q - 1'b1)
          begin
            state    <= rd_shift;
            cs_n     <= 1'b0;
            half_cnt <= '0;
            bit_cnt  <= '0;
          end
          else
            half_cnt <= half_cnt + 1'b1;
        end

        done:
          state <= idle;

        default:
          state <= idle;
      endcase
    end
  end

  // ****************************************
  // Shift register
  // ****************************************
  // Shared by both directions. The read byte ends up in the low bits.
  always_ff @(posedge clk)
  begin
    if (cmd_valid && cmd_ready)
      shift_q <= cmd;
    else if ((state == cmd_shift) && sclk_fall)
      shift_q <= {shift_q[`SPI_CMD_W-2:0], 1'b0};
    else if ((state == rd_shift) && sclk_rise)
      shift_q <= {shift_q[`SPI_CMD_W-2:0], miso}; // Slave data is stable at the rising edge.
  end

endmodule

`default_nettype wire

// File: rtl/spi_ctrl_top.sv
`default_nettype none

module spi_ctrl_top
  import spi_pkg::*;
(
  input  wire            clk,
  input  wire            rst_n,
  input  wire axi_addr_t awaddr,
  input  wire            awvalid,
  output wire            awready,
  input  wire axi_data_t wdata,
  input  wire            wvalid,
  output wire            wready,
  output wire [1:0]      bresp,
  output wire            bvalid,
  input  wire            bready,
  input  wire axi_addr_t araddr,
  input  wire            arvalid,
  output wire            arready,
  output wire axi_data_t rdata,
  output wire [1:0]      rresp,
  output wire            rvalid,
  input  wire            rready,
  output wire            sclk,
  output wire            cs_n,
  output wire            mosi,
  input  wire            miso
);

  wire spi_cmd_t  cmd;
  wire            cmd_valid;
  wire            cmd_ready;
  wire spi_cfg_t  cfg;
  wire            rd_valid;
  wire spi_byte_t rd_data;

  spi_axil_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cfg       (cfg),
    .cmd_ready (cmd_ready),
    .rd_valid  (rd_valid),
    .rd_data   (rd_data)
  );

  spi_cmd_engine u_engine (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cfg       (cfg),
    .rd_valid  (rd_valid),
    .rd_data   (rd_data),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .miso      (miso)
  );

endmodule

`default_nettype wire

// File: verification/spi_slave_model.sv
`default_nettype none

module spi_slave_model (
  input  wire  sclk,
  input  wire  cs_n,
  input  wire  mosi,
  output logic miso
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [7:0]  mem [0:7];
  logic [11:0] rx_q    = '0;
  logic [7:0]  tx_q    = '0;
  logic [2:0]  rd_addr = '0;
  logic        armed   = 1'b0;  // Set by a read header, cleared after the data frame.
  int          rx_cnt  = 0;

  initial
  begin
    miso = 1'b0;
    for (int a = 0; a < 8; a++)
      mem[a] = 8'(a * 'h11);
  end

  always @(negedge cs_n)
  begin
    rx_cnt = 0;
    if (armed)
    begin
      tx_q = mem[rd_addr];
      miso = tx_q[7];               // First bit is ready before the first rising edge.
    end
  end

  always @(posedge sclk)
  begin
    if (!cs_n)
    begin
      rx_q = {rx_q[10:0], mosi};
      rx_cnt++;
    end
  end

  always @(negedge sclk)
  begin
    if (!cs_n && armed)
    begin
      tx_q = {tx_q[6:0], 1'b0};
      miso = tx_q[7];
    end
  end

  // Frames are decoded when chip select is released.
  always @(posedge cs_n)
  begin
    if (armed)
      armed = 1'b0;
    else if ((rx_cnt == 12) && rx_q[11])
      mem[rx_q[10:8]] = rx_q[7:0];
    else if (rx_cnt == 4)
    begin
      armed   = 1'b1;
      rd_addr = rx_q[2:0];
    end
  end

endmodule

`default_nettype wire

// File: verification/tb_spi_ctrl_top.sv
`default_nettype none

`include "spi_defs.svh"

module tb_spi_ctrl_top
  import spi_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int         wait_limit = 2000;
  localparam logic [1:0] okay       = 2'b00;
  localparam logic [1:0] slverr     = 2'b10;

  typedef enum logic [1:0] {op_wr, op_rd, op_idle, op_frame} op_t;

  typedef struct packed {
    op_t        op;
    axi_addr_t  addr;
    axi_data_t  data;
    logic [1:0] resp;
    axi_data_t  exp;                // Expected read data, or clk_div for a frame.
  } step_t;

  logic           clk = 1'b0;
  logic           rst_n;
  axi_addr_t      awaddr;
  logic           awvalid;
  axi_data_t      wdata;
  logic           wvalid;
  logic           bready;
  axi_addr_t      araddr;
  logic           arvalid;
  logic           rready;
  wire            awready;
  wire            wready;
  wire [1:0]      bresp;
  wire            bvalid;
  wire            arready;
  wire axi_data_t rdata;
  wire [1:0]      rresp;
  wire            rvalid;
  wire            sclk;
  wire            cs_n;
  wire            mosi;
  wire            miso;
  step_t          steps[$];

  spi_ctrl_top dut (.*);

  spi_slave_model u_slave (.sclk(sclk), .cs_n(cs_n), .mosi(mosi), .miso(miso));

  always #20 clk = ~clk;

  // ****************************************
  // Helpers
  // ****************************************
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input axi_data_t act, input axi_data_t exp);
    if (act !== exp)
    begin
      $display("error %s: got 0x%0h, expected 0x%0h", name, act, exp);
      $display(">>> FAIL");
      $fatal(1);
    end
  endtask

  task automatic axi_write(input axi_addr_t addr, input axi_data_t data, output logic [1:0] resp);
    int n;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    n = 0;
    while (!awready)
    begin
      next_cycle();
      n++;
      if (n > wait_limit)
        abort_run("Timeout waiting for awready.");
    end
    next_cycle();
    awvalid = 1'b0;
    wvalid  = 1'b0;
    repeat ($urandom_range(0, 2)) next_cycle();  // Stall the response channel.
    n = 0;
    while (!bvalid)
    begin
      next_cycle();
      n++;
      if (n > wait_limit)
        abort_run("Timeout waiting for bvalid.");
    end
    bready = 1'b1;
    resp   = bresp;
    next_cycle();
    bready = 1'b0;
  endtask

  task automatic axi_read(input axi_addr_t addr, output axi_data_t data, output logic [1:0] resp);
    int n;
    araddr  = addr;
    arvalid = 1'b1;
    n = 0;
    while (!arready)
    begin
      next_cycle();
      n++;
      if (n > wait_limit)
        abort_run("Timeout waiting for arready.");
    end
    next_cycle();
    arvalid = 1'b0;
    repeat ($urandom_range(0, 2)) next_cycle();
    n = 0;
    while (!rvalid)
    begin
      next_cycle();
      n++;
      if (n > wait_limit)
        abort_run("Timeout waiting for rvalid.");
    end
    rready = 1'b1;
    data   = rdata;
    resp   = rresp;
    next_cycle();
    rready = 1'b0;
  endtask

  task automatic wait_idle();
    axi_data_t  status;
    logic [1:0] resp;
    int         n;
    status = 32'h1;
    n = 0;
    while (status[0])
    begin
      axi_read(`SPI_REG_STATUS, status, resp);
      n++;
      if (n > 500)
        abort_run("Timeout waiting for the busy flag to clear.");
    end
  endtask

  // Every interval between cs_n and sclk edges is clk_div cycles long.
  task automatic measure_frame(input int div);
    int   n;
    int   gap;
    int   rises;
    logic last_sclk;
    n = 0;
    while (cs_n)
    begin
      next_cycle();
      n++;
      if (n > wait_limit)
        abort_run("Timeout waiting for cs_n to fall.");
    end
    gap       = 0;
    rises     = 0;
    last_sclk = sclk;
    while (!cs_n)
    begin
      next_cycle();
      gap++;
      n++;
      if (n > wait_limit)
        abort_run("Timeout waiting for cs_n to rise.");
      if ((sclk != last_sclk) || cs_n)
      begin
        check_value("sclk half period", gap, div);
        rises     = rises + (sclk && !last_sclk);
        gap       = 0;
        last_sclk = sclk;
      end
    end
    check_value("sclk rising edges", rises, 12);
  endtask

  function automatic axi_data_t cmd_word(input logic wr, input spi_addr_t a, input spi_byte_t d);
    spi_cmd_t c;
    c = '{write: wr, addr: a, data: d};
    return axi_data_t'(c);
  endfunction

  function automatic void add_step(input op_t op, input axi_addr_t addr, input axi_data_t data,
                                   input logic [1:0] resp, input axi_data_t exp);
    steps.push_back('{op: op, addr: addr, data: data, resp: resp, exp: exp});
  endfunction

  // ****************************************
  // Stimulus table
  // ****************************************
  task automatic fill_steps();
    spi_byte_t d1;
    spi_byte_t d2;
    spi_byte_t d3;
    spi_byte_t d4;
    d1 = spi_byte_t'($urandom);
    d2 = spi_byte_t'($urandom);
    d3 = spi_byte_t'($urandom);
    d4 = spi_byte_t'($urandom);
    add_step(op_rd, `SPI_REG_CTRL, 0, okay, 32'h1004);
    add_step(op_rd, `SPI_REG_STATUS, 0, okay, 0);
    add_step(op_rd, `SPI_REG_RXDATA, 0, okay, 0);
    add_step(op_wr, `SPI_REG_STATUS, 32'hFF, okay, 0);
    add_step(op_rd, `SPI_REG_STATUS, 0, okay, 0);
    add_step(op_wr, `SPI_REG_CMD, cmd_word(1'b1, 3'd3, d1), okay, 0);
    add_step(op_idle, 0, 0, okay, 0);
    add_step(op_wr, `SPI_REG_CMD, cmd_word(1'b0, 3'd3, 8'h00), okay, 0);
    add_step(op_idle, 0, 0, okay, 0);
    add_step(op_rd, `SPI_REG_STATUS, 0, okay, 32'h2);
    add_step(op_rd, `SPI_REG_RXDATA, 0, okay, d1);
    add_step(op_rd, `SPI_REG_STATUS, 0, okay, 0);   // Cleared by the RXDATA read.
    add_step(op_rd, `SPI_REG_RXDATA, 0, okay, d1);
    add_step(op_wr, `SPI_REG_CMD, cmd_word(1'b0, 3'd5, 8'h00), okay, 0);
    add_step(op_idle, 0, 0, okay, 0);
    add_step(op_rd, `SPI_REG_RXDATA, 0, okay, 32'h55);
    add_step(op_wr, `SPI_REG_CTRL, 32'h1002, okay, 0);
    add_step(op_frame, 0, cmd_word(1'b1, 3'd1, d2), okay, 2);
    add_step(op_idle, 0, 0, okay, 0);
    add_step(op_wr, `SPI_REG_CMD, cmd_word(1'b0, 3'd1, 8'h00), okay, 0);
    add_step(op_idle, 0, 0, okay, 0);
    add_step(op_rd, `SPI_REG_RXDATA, 0, okay, d2);
    add_step(op_wr, `SPI_REG_CTRL, 32'h0406, okay, 0);
    add_step(op_frame, 0, cmd_word(1'b1, 3'd6, d3), okay, 6);
    add_step(op_idle, 0, 0, okay, 0);
    add_step(op_wr, `SPI_REG_CMD, cmd_word(1'b0, 3'd6, 8'h00), okay, 0);
    add_step(op_idle, 0, 0, okay, 0);
    add_step(op_rd, `SPI_REG_RXDATA, 0, okay, d3);
    add_step(op_wr, `SPI_REG_CMD, cmd_word(1'b1, 3'd2, d4), okay, 0);
    add_step(op_wr, `SPI_REG_CMD, cmd_word(1'b1, 3'd2, ~d4), slverr, 0);
    add_step(op_rd, `SPI_REG_STATUS, 0, okay, 32'h1);
    add_step(op_idle, 0, 0, okay, 0);
    add_step(op_wr, `SPI_REG_CMD, cmd_word(1'b0, 3'd2, 8'h00), okay, 0);
    add_step(op_idle, 0, 0, okay, 0);
    add_step(op_rd, `SPI_REG_RXDATA, 0, okay, d4);
    add_step(op_rd, 4'h1, 0, slverr, 0);            // Offsets outside the register map.
    add_step(op_rd, 4'h6, 0, slverr, 0);
    add_step(op_wr, 4'hE, 32'hA5, slverr, 0);
  endtask

  initial
  begin
    axi_data_t  data;
    logic [1:0] resp;
    void'($urandom(28));
    rst_n   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    fill_steps();
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    next_cycle();
    for (int i = 0; i < steps.size(); i++)
    begin
      case (steps[i].op)
        op_wr:
        begin
          axi_write(steps[i].addr, steps[i].data, resp);
          check_value($sformatf("bresp step %0d", i), resp, steps[i].resp);
        end
        op_rd:
        begin
          axi_read(steps[i].addr, data, resp);
          check_value($sformatf("rresp step %0d", i), resp, steps[i].resp);
          check_value($sformatf("rdata step %0d", i), data, steps[i].exp);
        end
        op_idle:
          wait_idle();
        op_frame:
        begin
          fork
            axi_write(`SPI_REG_CMD, steps[i].data, resp);
            measure_frame(steps[i].exp);
          join
          check_value($sformatf("bresp step %0d", i), resp, steps[i].resp);
        end
        default:
          abort_run("Unknown operation in the stimulus table.");
      endcase
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+rtl
rtl/spi_pkg.sv
rtl/spi_axil_regs.sv
rtl/spi_cmd_engine.sv
rtl/spi_ctrl_top.sv
verification/spi_slave_model.sv
verification/tb_spi_ctrl_top.sv
